/* common/exec_pkg.sv */
package exec_pkg;

    // --------------------------------------------------
    // Data width
    // --------------------------------------------------
    localparam int xlen_default = 32;                  // Top level default

    // --------------------------------------------------
    // ALU operation codes
    // --------------------------------------------------
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,                               // Signed compare
        alu_sltu = 4'd6,                               // Unsigned compare
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9                                // Sign fill
    } alu_op_e;

    // --------------------------------------------------
    // Instruction word, two decode views
    // --------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;                                       // Register-register format

    typedef struct packed {
        logic [11:0] imm12;                            // Also holds shamt for shifts
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;                                       // Register-immediate format

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    // Decoder to ALU and slave
    typedef struct packed {
        alu_op_e op;
        logic    illegal;                              // Not an OP or OP-IMM encoding
    } alu_ctrl_t;

    // Major opcodes
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    // APB register map
    localparam logic [4:0] reg_rs1    = 5'h00;
    localparam logic [4:0] reg_rs2    = 5'h04;
    localparam logic [4:0] reg_instr  = 5'h08;
    localparam logic [4:0] reg_result = 5'h0C;         // Read only
    localparam logic [4:0] reg_status = 5'h10;         // Read only, bit 0 sticky illegal

endpackage

/* alu/alu_adder.sv */
`timescale 1ns/1ps

module alu_adder #(
    parameter int XLEN = 32
) (
    input  logic            sub,                       // 1 selects a - b
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] sum
);

    logic [XLEN-1:0] b_sel;                            // b or its inverse
    logic [XLEN-1:0] b_inv;

    assign b_inv = ~b;

    // Two's complement subtract
    // Inverted operand plus carry-in of one
    assign b_sel = sub ? b_inv : b;
    assign sum   = a + b_sel + XLEN'(sub);             // Wraps at XLEN bits

endmodule

/* alu/alu.sv */
`timescale 1ns/1ps

module alu #(
    parameter int XLEN = 32
) (
    input  exec_pkg::alu_op_e op,
    input  logic [XLEN-1:0]   d1,                      // rs1 value
    input  logic [XLEN-1:0]   d2,                      // rs2 or immediate
    output logic [XLEN-1:0]   res
);

    import exec_pkg::*;

    localparam int shamt_w = $clog2(XLEN);             // 5 at RV32, 6 at RV64

    logic                 sub;                         // Adder mode
    logic [XLEN-1:0]      sum;                         // Adder output
    logic [shamt_w-1:0]   shamt;
    logic [2*XLEN-1:0]    sra_ext;                     // Sign-extended shift source

    // Only the low bits of d2 count for shifts
    assign shamt   = d2[shamt_w-1:0];
    assign sra_ext = {{XLEN{d1[XLEN-1]}}, d1} >> shamt;

    // --------------------------------------------------
    // Operation select
    // --------------------------------------------------
    always_comb begin
        sub = 1'b0;
        res = '0;
        case (op)
            alu_add: begin
                res = sum;
            end
            alu_sub: begin
                sub = 1'b1;
                res = sum;
            end
            alu_and: begin
                res = d1 & d2;
            end
            alu_or: begin
                res = d1 | d2;
            end
            alu_xor: begin
                res = d1 ^ d2;
            end
            alu_slt: begin
                sub = 1'b1;                            // Need d1 - d2
                if (d1[XLEN-1] != d2[XLEN-1])
                    res[0] = d1[XLEN-1];               // Negative one is smaller
                else
                    res[0] = sum[XLEN-1];              // Same sign, difference cannot overflow
            end
            alu_sltu: begin
                res[0] = (d1 < d2);
            end
            alu_sll: begin
                res = d1 << shamt;
            end
            alu_srl: begin
                res = d1 >> shamt;                     // Zero fill
            end
            alu_sra: begin
                res = sra_ext[XLEN-1:0];               // Low half keeps the sign fill
            end
            default: begin
                res = '0;
            end
        endcase
    end

    // Shared add/subtract path
    alu_adder #(
        .XLEN (XLEN)
    ) u_adder (
        .sub  (sub),
        .a    (d1),
        .b    (d2),
        .sum  (sum)
    );

endmodule

/* source/rv_alu_decode.sv */
`timescale 1ns/1ps

module rv_alu_decode #(
    parameter int XLEN = 32
) (
    input  exec_pkg::instr_u    instr_q,               // Registered instruction
    input  logic [XLEN-1:0]     pwdata,                // Instruction being written
    input  logic                wr_instr,
    input  logic [XLEN-1:0]     rs2_q,
    output exec_pkg::alu_ctrl_t ctrl,
    output logic [XLEN-1:0]     operand_b
);

    import exec_pkg::*;

    localparam int          shamt_w    = $clog2(XLEN);
    localparam logic [11:0] shamt_mask = 12'((1 << shamt_w) - 1);
    localparam logic [11:0] arith_bit  = 12'h400;      // Instruction bit 30

    instr_u  instr;                                    // Word under decode
    alu_op_e op_d;
    logic    illegal_d;
    logic    is_shift;                                 // funct3 names a shift

    // Live write data during the INSTR access, else the stored word
    assign instr    = wr_instr ? instr_u'(pwdata[31:0]) : instr_q;
    assign is_shift = (instr.i.funct3 == 3'b001) || (instr.i.funct3 == 3'b101);

    // --------------------------------------------------
    // funct3 / funct7 to operation
    // --------------------------------------------------
    always_comb begin
        illegal_d = 1'b0;
        case (instr.r.funct3)
            3'b000:  op_d = alu_add;
            3'b001:  op_d = alu_sll;
            3'b010:  op_d = alu_slt;
            3'b011:  op_d = alu_sltu;
            3'b100:  op_d = alu_xor;
            3'b101:  op_d = instr.r.funct7[5] ? alu_sra : alu_srl;
            3'b110:  op_d = alu_or;
            default: op_d = alu_and;
        endcase
        case (instr.r.opcode)
            opcode_op: begin
                if (instr.r.funct7 == 7'h20) begin
                    if (instr.r.funct3 == 3'b000)
                        op_d = alu_sub;
                    else if (instr.r.funct3 != 3'b101)
                        illegal_d = 1'b1;              // Only SUB and SRA use bit 30
                end else if (instr.r.funct7 != 7'h00) begin
                    illegal_d = 1'b1;
                end
            end
            opcode_op_imm: begin
                if (instr.i.funct3 == 3'b001)          // SLLI, upper field all zero
                    illegal_d = |(instr.i.imm12 & ~shamt_mask);
                else if (instr.i.funct3 == 3'b101)     // SRLI or SRAI
                    illegal_d = |(instr.i.imm12 & ~shamt_mask & ~arith_bit);
            end
            default: illegal_d = 1'b1;                 // No other opcode here
        endcase
    end

    // Second operand select
    always_comb begin
        if (instr.r.opcode == opcode_op)
            operand_b = rs2_q;
        else if (is_shift)
            operand_b = XLEN'(instr.i.imm12[shamt_w-1:0]);      // Zero-extended shamt
        else
            operand_b = {{(XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
    end

    assign ctrl = '{op: op_d, illegal: illegal_d};

endmodule

/* source/exec_apb_slave.sv */
`timescale 1ns/1ps

module exec_apb_slave #(
    parameter int XLEN = 32
) (
    input  logic                clock,
    input  logic                rst_n,
    input  logic [4:0]          paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [XLEN-1:0]     pwdata,
    output logic [XLEN-1:0]     prdata,
    output logic                pready,
    output logic                pslverr,
    input  exec_pkg::alu_ctrl_t ctrl,                  // From decoder
    input  logic [XLEN-1:0]     res,                   // From ALU
    output logic [XLEN-1:0]     rs1_q,
    output logic [XLEN-1:0]     rs2_q,
    output exec_pkg::instr_u    instr_q,
    output logic                wr_instr               // INSTR write in access cycle
);

    import exec_pkg::*;

    logic [XLEN-1:0] result_q;
    logic            status_q;                         // Sticky illegal bit
    logic            capture_q;                        // Latch res next edge
    logic            access;                           // psel and penable
    logic            wr_access;
    logic            sel_rs1;
    logic            sel_rs2;
    logic            sel_instr;
    logic            sel_result;
    logic            sel_status;
    logic            mapped;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    assign sel_rs1    = (paddr == reg_rs1);
    assign sel_rs2    = (paddr == reg_rs2);
    assign sel_instr  = (paddr == reg_instr);
    assign sel_result = (paddr == reg_result);
    assign sel_status = (paddr == reg_status);
    assign mapped     = sel_rs1 | sel_rs2 | sel_instr | sel_result | sel_status;

    assign access    = psel & penable;
    assign wr_access = access & pwrite;
    assign wr_instr  = wr_access & sel_instr;

    assign pready  = 1'b1;                             // Zero wait states
    assign pslverr = access & (~mapped
                               | (pwrite & (sel_result | sel_status))
                               | (wr_instr & ctrl.illegal));

    // Read mux, zero outside a read access
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (1'b1)
                sel_rs1:    prdata = rs1_q;
                sel_rs2:    prdata = rs2_q;
                sel_instr:  prdata = XLEN'(instr_q);
                sel_result: prdata = result_q;
                sel_status: prdata = XLEN'(status_q);
                default:    prdata = '0;           // Unmapped
            endcase
        end
    end

    // --------------------------------------------------
    // Registers
    // --------------------------------------------------
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rs1_q     <= '0;
            rs2_q     <= '0;
            instr_q   <= '0;
            result_q  <= '0;
            status_q  <= 1'b0;
            capture_q <= 1'b0;
        end else begin
            capture_q <= wr_instr & ~ctrl.illegal;   // One cycle pulse
            if (wr_access && sel_rs1)
                rs1_q <= pwdata;
            if (wr_access && sel_rs2)
                rs2_q <= pwdata;
            if (wr_instr) begin
                status_q <= ctrl.illegal;            // Legal write clears
                if (!ctrl.illegal)
                    instr_q <= instr_u'(pwdata[31:0]);
            end
            if (capture_q)
                result_q <= res;                     // Decode of new instr_q
        end
    end

endmodule

/* source/exec_unit_top.sv */
`timescale 1ns/1ps

module exec_unit_top #(
    parameter int XLEN = exec_pkg::xlen_default
) (
    input  logic            clock,
    input  logic            rst_n,
    input  logic [4:0]      paddr,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [XLEN-1:0] pwdata,
    output logic [XLEN-1:0] prdata,
    output logic            pready,
    output logic            pslverr
);

    import exec_pkg::*;

    logic [XLEN-1:0] rs1_q;                            // Operand A
    logic [XLEN-1:0] rs2_q;
    logic [XLEN-1:0] operand_b;                        // rs2 or immediate
    logic [XLEN-1:0] res;
    instr_u          instr_q;
    logic            wr_instr;
    alu_ctrl_t       ctrl;

    // --------------------------------------------------
    // APB register block
    // --------------------------------------------------
    exec_apb_slave #(
        .XLEN     (XLEN)
    ) u_slave (
        .clock    (clock),
        .rst_n    (rst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .ctrl     (ctrl),
        .res      (res),
        .rs1_q    (rs1_q),
        .rs2_q    (rs2_q),
        .instr_q  (instr_q),
        .wr_instr (wr_instr)
    );

    // Instruction decode
    rv_alu_decode #(
        .XLEN      (XLEN)
    ) u_decode (
        .instr_q   (instr_q),
        .pwdata    (pwdata),
        .wr_instr  (wr_instr),
        .rs2_q     (rs2_q),
        .ctrl      (ctrl),
        .operand_b (operand_b)
    );

    // Execute
    alu #(
        .XLEN (XLEN)
    ) u_alu (
        .op   (ctrl.op),
        .d1   (rs1_q),
        .d2   (operand_b),
        .res  (res)
    );

endmodule

/* test/exec_unit_properties.sv */
`timescale 1ns/1ps

module exec_unit_properties #(
    parameter int XLEN = 32
) (
    input logic            clock,
    input logic            rst_n,
    input logic            psel,
    input logic            penable,
    input logic            pready,
    input logic            pslverr,
    input logic            capture_q,                  // Slave capture pulse
    input logic [XLEN-1:0] result_q
);

    int fail_count = 0;                                // Read by the testbench

    // --------------------------------------------------
    // APB response
    // --------------------------------------------------
    a_pready_high: assert property (@(posedge clock) disable iff (!rst_n) pready)
    else begin
        $error("pready dropped low");
        fail_count++;
    end

    a_slverr_in_access: assert property (@(posedge clock) disable iff (!rst_n)
        pslverr |-> (psel && penable))
    else begin
        $error("pslverr outside an access cycle");
        fail_count++;
    end

    // Result moves only one edge after a capture pulse
    a_result_stable: assert property (@(posedge clock) disable iff (!rst_n)
        !$past(capture_q) |-> $stable(result_q))
    else begin
        $error("result register changed without a capture");
        fail_count++;
    end

endmodule

bind exec_unit_top exec_unit_properties #(
    .XLEN      (XLEN)
) u_props (
    .clock     (clock),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pslverr   (pslverr),
    .capture_q (u_slave.capture_q),
    .result_q  (u_slave.result_q)
);

/* test/exec_unit_tb.sv */
`timescale 1ns/1ps

module exec_unit_tb;

    import exec_pkg::*;

    localparam int XLEN     = 32;
    localparam int clk_half = 50;                      // 100 ns period
    localparam int n_random = 20;                      // Random R-type count

    logic            clock;
    logic            rst_n;
    logic [4:0]      paddr;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [XLEN-1:0] pwdata;
    logic [XLEN-1:0] prdata;
    logic            pready;
    logic            pslverr;

    logic [31:0] g_rs1[$];                             // Golden vectors
    logic [31:0] g_rs2[$];
    logic [31:0] g_instr[$];
    logic [31:0] g_res[$];
    logic        g_err[$];
    logic        vectors_ready = 1'b0;                 // Starts the watchdog
    int          errors = 0;
    integer      seed;

    exec_unit_top #(
        .XLEN    (XLEN)
    ) u_dut (
        .clock   (clock),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #(clk_half) clock = ~clock;

    // --------------------------------------------------
    // Compare and report
    // --------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // APB transfers, setup then access, sampled mid access cycle
    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clock);
        penable = 1'b1;
        #(clk_half / 2);
        while (pready !== 1'b1) begin                  // Watchdog bounds this
            @(negedge clock);
            #(clk_half / 2);
        end
        err = pslverr;
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clock);
        penable = 1'b1;
        #(clk_half / 2);
        while (pready !== 1'b1) begin
            @(negedge clock);
            #(clk_half / 2);
        end
        data = prdata;
        err  = pslverr;
    endtask

    task automatic release_bus();
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Five transfers per vector
    task automatic run_vector(input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] word, input logic [31:0] exp_res,
                              input logic exp_err);
        logic        err;
        logic [31:0] data;
        apb_write(reg_rs1, a, err);
        apb_write(reg_rs2, b, err);
        apb_write(reg_instr, word, err);
        check_value("pslverr", 32'(err), 32'(exp_err));   // Illegal word flagged live
        apb_read(reg_result, data, err);
        check_value("result", data, exp_res);
        apb_read(reg_status, data, err);
        check_value("status", data, 32'(exp_err));
    endtask

    // Golden file, lines starting with # skipped
    task automatic load_golden();
        int          fd;
        string       line;
        logic [31:0] v_rs1;
        logic [31:0] v_rs2;
        logic [31:0] v_instr;
        logic [31:0] v_res;
        logic [31:0] v_err;
        fd = $fopen("test/exec_unit_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden vector file test/exec_unit_golden.txt");
            $display("Test failed");
            $fatal(1, "Missing golden file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h %h %h", v_rs1, v_rs2, v_instr, v_res, v_err) == 5) begin
                    g_rs1.push_back(v_rs1);
                    g_rs2.push_back(v_rs2);
                    g_instr.push_back(v_instr);
                    g_res.push_back(v_res);
                    g_err.push_back(v_err[0]);
                end
            end
        end
        $fclose(fd);
        if (g_rs1.size() == 0) begin
            $display("The golden vector file holds no vectors");
            $display("Test failed");
            $fatal(1, "Empty golden file");
        end
    endtask

    // --------------------------------------------------
    // Watchdog
    // --------------------------------------------------
    initial begin : watchdog
        longint limit_ns;
        wait (vectors_ready);
        limit_ns = longint'(g_rs1.size() + n_random) * 5 * 2 * (2 * clk_half) + 2000;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin : main
        logic        err;
        logic [31:0] data;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] word;
        logic [31:0] exp_res;
        int          sel;
        clock   = 1'b0;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        seed    = 32'h1540;
        load_golden();
        vectors_ready = 1'b1;
        repeat (2) @(posedge clock);                   // Two cycles in reset
        @(negedge clock);
        rst_n = 1'b1;

        // Golden playback
        foreach (g_rs1[i])
            run_vector(g_rs1[i], g_rs2[i], g_instr[i], g_res[i], g_err[i]);

        // Random ADD / SUB / XOR, model from the RV32I definitions
        exp_res = '0;
        for (int k = 0; k < n_random; k++) begin
            a   = $random(seed);
            b   = $random(seed);
            sel = $unsigned($random(seed)) % 3;
            case (sel)
                0: begin
                    word    = 32'h002081B3;            // add x3, x1, x2
                    exp_res = a + b;
                end
                1: begin
                    word    = 32'h402081B3;            // sub
                    exp_res = a - b;
                end
                default: begin
                    word    = 32'h0020C1B3;            // xor
                    exp_res = a ^ b;
                end
            endcase
            run_vector(a, b, word, exp_res, 1'b0);
        end

        // Bus errors
        apb_write(reg_result, 32'hDEADBEEF, err);
        check_value("pslverr write result", 32'(err), 32'd1);
        apb_read(reg_result, data, err);
        check_value("result after rejected write", data, exp_res);
        apb_read(5'h14, data, err);
        check_value("pslverr read unmapped", 32'(err), 32'd1);
        check_value("prdata unmapped", data, 32'd0);
        apb_write(5'h1C, 32'h12345678, err);
        check_value("pslverr write unmapped", 32'(err), 32'd1);
        release_bus();

        @(negedge clock);
        check_value("assertion failures", 32'(u_dut.u_props.fail_count), 32'd0);
        if (errors == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "Checks failed");
        end
    end

endmodule

/* test/exec_unit_golden.txt */
# Columns, all hex: rs1 rs2 instruction expected_result expected_error
# Error 1 means pslverr on the INSTR write and STATUS 1, RESULT held
00000005 00000003 002081B3 00000008 0
FFFFFFFF 00000002 002081B3 00000001 0
00000003 00000005 402081B3 FFFFFFFE 0
80000000 00000001 402081B3 7FFFFFFF 0
F0F0F0F0 0FF00FF0 0020F1B3 00F000F0 0
F0F0F0F0 0FF00FF0 0020E1B3 FFF0FFF0 0
F0F0F0F0 0FF00FF0 0020C1B3 FF00FF00 0
00000010 00000000 FFF08193 0000000F 0
00001000 00000000 80008193 00000800 0
12345678 00000000 FF00F193 12345670 0
00000012 00000000 F000E193 FFFFFF12 0
0000FFFF 00000000 FFF0C193 FFFF0000 0
80000000 00000001 0020A1B3 00000001 0
80000000 00000001 0020B1B3 00000000 0
00000001 80000000 0020B1B3 00000001 0
80000000 00000000 0010A193 00000001 0
80000000 00000000 0010B193 00000000 0
00000005 00000000 FFF0B193 00000001 0
00000001 00000024 002091B3 00000010 0
80000000 00000021 0020D1B3 40000000 0
80000000 0000003F 4020D1B3 FFFFFFFF 0
0000000F 00000000 00409193 000000F0 0
F0000000 00000000 0080D193 00F00000 0
F0000000 00000000 4080D193 FFF00000 0
00000001 00000001 0000007F FFF00000 1
00000001 00000001 022081B3 FFF00000 1
00000001 00000001 002081B3 00000002 0

/* exec_unit_top.f */
common/exec_pkg.sv
alu/alu_adder.sv
alu/alu.sv
source/rv_alu_decode.sv
source/exec_apb_slave.sv
source/exec_unit_top.sv
test/exec_unit_properties.sv
test/exec_unit_tb.sv
